/* source/ul_oran_pkg.sv */
`default_nettype none

package ul_oran_pkg;

  // ********************
  // field widths
  // ********************

  // symbol index within a slot, 0 to 13.
  typedef logic [3:0] symbol_t;

  // section tag carried along with a request.
  typedef logic [7:0] section_t;

  // request word, symbol on top and section below.
  typedef logic [$bits(symbol_t)+$bits(section_t)-1:0] req_word_t;

  // one beat of the response stream.
  typedef logic [15:0] data_t;

  // ********************
  // sender FSM
  // ********************

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    PAYLOAD
  } send_state_t;

  // lfsr start value after reset.
  localparam data_t PRBS_SEED = 16'hACE1;

endpackage

`default_nettype wire

/* source/request_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module request_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   wr_strb_i,
  input  ul_oran_pkg::req_word_t wr_word_i,
  input  logic                   rd_pop_i,
  output logic                   empty_o,
  output ul_oran_pkg::req_word_t head_o,
  output logic                   ovfl_o
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  ul_oran_pkg::req_word_t mem [FIFO_DEPTH];
  logic [PW-1:0]          wr_ptr_q;
  logic [PW-1:0]          rd_ptr_q;
  logic [CW-1:0]          count_q;
  logic                   full;
  logic                   do_wr;
  logic                   do_pop;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == CW'(FIFO_DEPTH));
  assign head_o  = mem[rd_ptr_q];

  // a write into a full FIFO is dropped.
  assign do_wr  = wr_strb_i && !full;
  assign do_pop = rd_pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_word_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovfl_o   <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // one-cycle pulse, the cycle after the lost write.
      ovfl_o <= wr_strb_i && full;
    end
  end

endmodule

`default_nettype wire

/* source/response_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module response_sender #(
  parameter int NA         = 4,
  parameter int RESP_BEATS = 8
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     fifo_empty_i,
  input  ul_oran_pkg::req_word_t   fifo_head_i,
  input  logic [$clog2(NA)-1:0]    rd_antenna_i,
  input  ul_oran_pkg::symbol_t     rd_symbol_i,
  output logic                     pop_o,
  input  logic                     resp_ready_i,
  output logic                     resp_valid_o,
  output ul_oran_pkg::data_t       resp_data_o,
  output ul_oran_pkg::send_state_t state_o
);

  localparam int AW = $clog2(NA);
  localparam int BW = $clog2(RESP_BEATS + 1);

  ul_oran_pkg::send_state_t state_q;
  logic [BW-1:0]            beat_q;
  ul_oran_pkg::data_t       lfsr_q;
  logic                     lfsr_fb;
  ul_oran_pkg::req_word_t   word_q;
  logic [AW-1:0]            ant_q;
  ul_oran_pkg::data_t       header;
  logic                     xfer;

  // take the head only when its symbol is the one in the FFT buffer.
  assign pop_o = (state_q == ul_oran_pkg::IDLE) && !fifo_empty_i &&
                 (fifo_head_i[11:8] == rd_symbol_i);

  assign resp_valid_o = (state_q != ul_oran_pkg::IDLE);
  assign xfer         = resp_valid_o && resp_ready_i;
  assign state_o      = state_q;

  // x^16 + x^14 + x^13 + x^11 + 1, shifted left.
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // header is antenna on top, zero pad, request word below.
  always_comb begin
    header           = '0;
    header[15 -: AW] = ant_q;
    header[11:0]     = word_q;
  end

  assign resp_data_o = (state_q == ul_oran_pkg::HEADER) ? header : lfsr_q;

  always_ff @(posedge clk) begin
    if (pop_o) begin
      word_q <= fifo_head_i;
      ant_q  <= rd_antenna_i;
    end
  end

  // ********************
  // FSM and PRBS
  // ********************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ul_oran_pkg::IDLE;
      beat_q  <= '0;
      lfsr_q  <= ul_oran_pkg::PRBS_SEED;
    end else begin
      case (state_q)
        ul_oran_pkg::IDLE: begin
          if (pop_o) begin
            state_q <= ul_oran_pkg::HEADER;
          end
        end
        ul_oran_pkg::HEADER: begin
          if (xfer) begin
            state_q <= ul_oran_pkg::PAYLOAD;
            beat_q  <= '0;
          end
        end
        ul_oran_pkg::PAYLOAD: begin
          if (xfer) begin
            // the sequence runs on across responses.
            lfsr_q <= {lfsr_q[14:0], lfsr_fb};
            if (beat_q == BW'(RESP_BEATS - 1)) begin
              state_q <= ul_oran_pkg::IDLE;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        default: state_q <= ul_oran_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/alarm_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module alarm_counter #(
  parameter int CB = 4
) (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          alarm_i,
  input  logic          clear_i,
  output logic [CB-1:0] count_o
);

  // clear wins over an alarm in the same cycle.
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (clear_i) begin
      count_o <= '0;
    end else if (alarm_i && (count_o != '1)) begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/alarm_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module alarm_monitor #(
  parameter int NA                = 4,
  parameter int NC                = 2,
  parameter int CB                = 4,
  parameter int VLD_WO_RDY_THRESH = 26
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                clear_i,
  input  logic [NC-1:0]                       resp_valid_i,
  input  logic [NC-1:0]                       resp_ready_i,
  input  logic [NA-1:0]                       fifo_ovfl_i,
  input  logic [NA-1:0]                       fifo_empty_i,
  input  ul_oran_pkg::req_word_t [NA-1:0]     fifo_head_i,
  input  logic [NC-1:0]                       fft_wr_pointer_x_i,
  input  logic [NC-1:0][$clog2(NA)-1:0]       fft_rd_antenna_i,
  input  ul_oran_pkg::symbol_t [NC-1:0]       fft_rd_symbol_i,
  input  ul_oran_pkg::send_state_t [NC-1:0]   send_state_i,
  output logic [NC-1:0][CB-1:0]               vld_wo_rdy_cnt_o,
  output logic [NA-1:0][CB-1:0]               fifo_ovfl_cnt_o,
  output logic [NA-1:0][CB-1:0]               stale_reqs_cnt_o,
  output logic [NA-1:0][CB-1:0]               stale_prbs_cnt_o
);

  localparam int AW           = $clog2(NA);
  localparam int SW           = $clog2(VLD_WO_RDY_THRESH + 1);
  localparam int FANOUT_DEPTH = 4;

  logic                              clear_0;
  logic                              clear_1;
  logic [FANOUT_DEPTH-1:0]           clear_fan;
  logic [NC-1:0]                     valid_q;
  logic [NC-1:0]                     ready_q;
  logic [NA-1:0]                     ovfl_q;
  logic [NA-1:0]                     empty_q;
  ul_oran_pkg::req_word_t [NA-1:0]   head_q;
  logic [NC-1:0]                     wr_x_q;
  logic [NC-1:0][AW-1:0]             rd_ant_q;
  ul_oran_pkg::symbol_t [NC-1:0]     rd_sym_q;
  ul_oran_pkg::send_state_t [NC-1:0] state_q;
  logic [NC-1:0][SW-1:0]             stall_q;
  logic [NC-1:0]                     stall_alarm;
  logic [NC-1:0]                     stale_req_q;
  logic [NC-1:0]                     stale_prbs_q;
  logic [NC-1:0][AW-1:0]             alarm_ant_q;
  logic [NA-1:0]                     stale_req_ant;
  logic [NA-1:0]                     stale_prbs_ant;

  always_ff @(posedge clk) begin
    head_q      <= fifo_head_i;
    rd_ant_q    <= fft_rd_antenna_i;
    rd_sym_q    <= fft_rd_symbol_i;
    // keeps the antenna in step with the stale flags.
    alarm_ant_q <= rd_ant_q;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clear_0      <= 1'b0;
      clear_1      <= 1'b0;
      clear_fan    <= '0;
      valid_q      <= '0;
      ready_q      <= '0;
      ovfl_q       <= '0;
      empty_q      <= '1;
      wr_x_q       <= '0;
      stall_q      <= '0;
      stall_alarm  <= '0;
      stale_req_q  <= '0;
      stale_prbs_q <= '0;
      for (int c = 0; c < NC; c++) begin
        state_q[c] <= ul_oran_pkg::IDLE;
      end
    end else begin
      // rising edge of clear, then a short pipeline for fanout.
      clear_0   <= clear_i;
      clear_1   <= clear_0;
      clear_fan <= {clear_fan[FANOUT_DEPTH-2:0], clear_0 & ~clear_1};

      valid_q <= resp_valid_i;
      ready_q <= resp_ready_i;
      ovfl_q  <= fifo_ovfl_i;
      empty_q <= fifo_empty_i;
      wr_x_q  <= fft_wr_pointer_x_i;

      for (int c = 0; c < NC; c++) begin
        state_q[c] <= send_state_i[c];

        // stall count sticks at the threshold until valid drops.
        if (!valid_q[c]) begin
          stall_q[c] <= '0;
        end else if (!ready_q[c] && (stall_q[c] != SW'(VLD_WO_RDY_THRESH))) begin
          stall_q[c] <= stall_q[c] + 1'b1;
        end
        stall_alarm[c] <= valid_q[c] && !ready_q[c] &&
                          (stall_q[c] == SW'(VLD_WO_RDY_THRESH - 1));

        stale_req_q[c]  <= wr_x_q[c] && !empty_q[rd_ant_q[c]] &&
                           (head_q[rd_ant_q[c]][11:8] == rd_sym_q[c]);
        stale_prbs_q[c] <= wr_x_q[c] && (state_q[c] != ul_oran_pkg::IDLE);
      end
    end
  end

  // ********************
  // route carrier flags to antennas
  // ********************

  always_comb begin
    stale_req_ant  = '0;
    stale_prbs_ant = '0;
    for (int k = 0; k < NA; k++) begin
      for (int c = 0; c < NC; c++) begin
        if (alarm_ant_q[c] == AW'(k)) begin
          stale_req_ant[k]  = stale_req_ant[k] | stale_req_q[c];
          stale_prbs_ant[k] = stale_prbs_ant[k] | stale_prbs_q[c];
        end
      end
    end
  end

  genvar gc;
  genvar gk;

  for (gc = 0; gc < NC; gc++) begin : g_stall
    alarm_counter #(.CB(CB)) i_vld_wo_rdy_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .alarm_i (stall_alarm[gc]),
      .clear_i (clear_fan[FANOUT_DEPTH-1]),
      .count_o (vld_wo_rdy_cnt_o[gc])
    );
  end

  for (gk = 0; gk < NA; gk++) begin : g_ant
    alarm_counter #(.CB(CB)) i_fifo_ovfl_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .alarm_i (ovfl_q[gk]),
      .clear_i (clear_fan[FANOUT_DEPTH-1]),
      .count_o (fifo_ovfl_cnt_o[gk])
    );

    alarm_counter #(.CB(CB)) i_stale_reqs_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .alarm_i (stale_req_ant[gk]),
      .clear_i (clear_fan[FANOUT_DEPTH-1]),
      .count_o (stale_reqs_cnt_o[gk])
    );

    alarm_counter #(.CB(CB)) i_stale_prbs_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .alarm_i (stale_prbs_ant[gk]),
      .clear_i (clear_fan[FANOUT_DEPTH-1]),
      .count_o (stale_prbs_cnt_o[gk])
    );
  end

endmodule

`default_nettype wire

/* source/ul_oran_alarm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ul_oran_alarm_top #(
  parameter int NA                = 4,
  parameter int NC                = 2,
  parameter int FIFO_DEPTH        = 4,
  parameter int RESP_BEATS        = 8,
  parameter int CB                = 4,
  parameter int VLD_WO_RDY_THRESH = 26
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic [NA-1:0]                     req_strb_i,
  input  ul_oran_pkg::req_word_t [NA-1:0]   req_word_i,
  input  logic [NC-1:0][$clog2(NA)-1:0]     fft_rd_antenna_i,
  input  ul_oran_pkg::symbol_t [NC-1:0]     fft_rd_symbol_i,
  input  logic [NC-1:0]                     fft_wr_pointer_x_i,
  input  logic [NC-1:0]                     resp_ready_i,
  input  logic                              clear_i,
  output logic [NC-1:0]                     resp_valid_o,
  output ul_oran_pkg::data_t [NC-1:0]       resp_data_o,
  output logic [NC-1:0][CB-1:0]             vld_wo_rdy_cnt_o,
  output logic [NA-1:0][CB-1:0]             fifo_ovfl_cnt_o,
  output logic [NA-1:0][CB-1:0]             stale_reqs_cnt_o,
  output logic [NA-1:0][CB-1:0]             stale_prbs_cnt_o
);

  localparam int AW = $clog2(NA);

  logic [NA-1:0]                     fifo_empty;
  ul_oran_pkg::req_word_t [NA-1:0]   fifo_head;
  logic [NA-1:0]                     fifo_ovfl;
  logic [NA-1:0]                     fifo_pop;
  logic [NC-1:0]                     sel_empty;
  ul_oran_pkg::req_word_t [NC-1:0]   sel_head;
  logic [NC-1:0]                     send_pop;
  ul_oran_pkg::send_state_t [NC-1:0] send_state;

  // each antenna pops when a carrier reading it pops.
  always_comb begin
    fifo_pop = '0;
    for (int k = 0; k < NA; k++) begin
      for (int c = 0; c < NC; c++) begin
        if (fft_rd_antenna_i[c] == AW'(k)) begin
          fifo_pop[k] = fifo_pop[k] | send_pop[c];
        end
      end
    end
  end

  genvar ga;
  genvar gc;

  for (ga = 0; ga < NA; ga++) begin : g_fifo
    request_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_request_fifo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wr_strb_i (req_strb_i[ga]),
      .wr_word_i (req_word_i[ga]),
      .rd_pop_i  (fifo_pop[ga]),
      .empty_o   (fifo_empty[ga]),
      .head_o    (fifo_head[ga]),
      .ovfl_o    (fifo_ovfl[ga])
    );
  end

  for (gc = 0; gc < NC; gc++) begin : g_send
    // FIFO selected by the carrier's read antenna.
    assign sel_empty[gc] = fifo_empty[fft_rd_antenna_i[gc]];
    assign sel_head[gc]  = fifo_head[fft_rd_antenna_i[gc]];

    response_sender #(
      .NA         (NA),
      .RESP_BEATS (RESP_BEATS)
    ) i_response_sender (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fifo_empty_i (sel_empty[gc]),
      .fifo_head_i  (sel_head[gc]),
      .rd_antenna_i (fft_rd_antenna_i[gc]),
      .rd_symbol_i  (fft_rd_symbol_i[gc]),
      .pop_o        (send_pop[gc]),
      .resp_ready_i (resp_ready_i[gc]),
      .resp_valid_o (resp_valid_o[gc]),
      .resp_data_o  (resp_data_o[gc]),
      .state_o      (send_state[gc])
    );
  end

  alarm_monitor #(
    .NA                (NA),
    .NC                (NC),
    .CB                (CB),
    .VLD_WO_RDY_THRESH (VLD_WO_RDY_THRESH)
  ) i_alarm_monitor (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .clear_i            (clear_i),
    .resp_valid_i       (resp_valid_o),
    .resp_ready_i       (resp_ready_i),
    .fifo_ovfl_i        (fifo_ovfl),
    .fifo_empty_i       (fifo_empty),
    .fifo_head_i        (fifo_head),
    .fft_wr_pointer_x_i (fft_wr_pointer_x_i),
    .fft_rd_antenna_i   (fft_rd_antenna_i),
    .fft_rd_symbol_i    (fft_rd_symbol_i),
    .send_state_i       (send_state),
    .vld_wo_rdy_cnt_o   (vld_wo_rdy_cnt_o),
    .fifo_ovfl_cnt_o    (fifo_ovfl_cnt_o),
    .stale_reqs_cnt_o   (stale_reqs_cnt_o),
    .stale_prbs_cnt_o   (stale_prbs_cnt_o)
  );

endmodule

`default_nettype wire

/* verif/tb_ul_oran_alarm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ul_oran_alarm_top;

  localparam int NA                = 4;
  localparam int NC                = 2;
  localparam int FIFO_DEPTH        = 4;
  localparam int RESP_BEATS        = 8;
  localparam int CB                = 4;
  localparam int VLD_WO_RDY_THRESH = 26;
  localparam int AW                = $clog2(NA);

  logic                  clk;
  logic                  rst_n_i;
  logic [NA-1:0]         req_strb_i;
  logic [NA-1:0][11:0]   req_word_i;
  logic [NC-1:0][AW-1:0] fft_rd_antenna_i;
  logic [NC-1:0][3:0]    fft_rd_symbol_i;
  logic [NC-1:0]         fft_wr_pointer_x_i;
  logic [NC-1:0]         resp_ready_i;
  logic                  clear_i;
  logic [NC-1:0]         resp_valid_o;
  logic [NC-1:0][15:0]   resp_data_o;
  logic [NC-1:0][CB-1:0] vld_wo_rdy_cnt_o;
  logic [NA-1:0][CB-1:0] fifo_ovfl_cnt_o;
  logic [NA-1:0][CB-1:0] stale_reqs_cnt_o;
  logic [NA-1:0][CB-1:0] stale_prbs_cnt_o;

  // reference model of the FIFOs and of each carrier's stream.
  logic [11:0] model_fifo [NA][FIFO_DEPTH];
  int          model_size [NA];
  logic [15:0] exp_header [NC];
  logic [15:0] model_lfsr [NC];
  int          beat_idx [NC];
  bit          busy [NC];
  int          errors;
  int          checks;
  int          wd_cycles;

  ul_oran_alarm_top #(
    .NA                (NA),
    .NC                (NC),
    .FIFO_DEPTH        (FIFO_DEPTH),
    .RESP_BEATS        (RESP_BEATS),
    .CB                (CB),
    .VLD_WO_RDY_THRESH (VLD_WO_RDY_THRESH)
  ) i_ul_oran_alarm_top (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .req_strb_i         (req_strb_i),
    .req_word_i         (req_word_i),
    .fft_rd_antenna_i   (fft_rd_antenna_i),
    .fft_rd_symbol_i    (fft_rd_symbol_i),
    .fft_wr_pointer_x_i (fft_wr_pointer_x_i),
    .resp_ready_i       (resp_ready_i),
    .clear_i            (clear_i),
    .resp_valid_o       (resp_valid_o),
    .resp_data_o        (resp_data_o),
    .vld_wo_rdy_cnt_o   (vld_wo_rdy_cnt_o),
    .fifo_ovfl_cnt_o    (fifo_ovfl_cnt_o),
    .stale_reqs_cnt_o   (stale_reqs_cnt_o),
    .stale_prbs_cnt_o   (stale_prbs_cnt_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic advance_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, shift left, feedback into bit 0.
  function automatic logic [15:0] next_prbs(input logic [15:0] v);
    return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
  endfunction

  // ********************
  // stream scoreboard
  // ********************

  // sampled mid-cycle, where valid, ready and data are settled.
  always @(negedge clk) begin : scoreboard
    logic [NA-1:0] was_full;
    bit            was_busy;
    int            ant;
    if (rst_n_i) begin
      for (int k = 0; k < NA; k++) begin
        was_full[k] = (model_size[k] == FIFO_DEPTH);
      end
      for (int c = 0; c < NC; c++) begin
        was_busy = busy[c];
        compare_value($sformatf("resp_valid_o[%0d]", c), 32'(resp_valid_o[c]),
                      32'(busy[c]));
        if (busy[c] && resp_valid_o[c]) begin
          // the beat stays put while ready is low.
          if (beat_idx[c] == 0) begin
            compare_value($sformatf("resp_data_o[%0d]", c), 32'(resp_data_o[c]),
                          32'(exp_header[c]));
          end else begin
            compare_value($sformatf("resp_data_o[%0d]", c), 32'(resp_data_o[c]),
                          32'(model_lfsr[c]));
          end
          if (resp_ready_i[c]) begin
            if (beat_idx[c] != 0) begin
              model_lfsr[c] = next_prbs(model_lfsr[c]);
            end
            if (beat_idx[c] == RESP_BEATS) begin
              busy[c] = 1'b0;
            end else begin
              beat_idx[c]++;
            end
          end
        end
        // an idle sender takes the head once its symbol is in the buffer.
        ant = int'(fft_rd_antenna_i[c]);
        if (!was_busy && model_size[ant] > 0 &&
            model_fifo[ant][0][11:8] == fft_rd_symbol_i[c]) begin
          exp_header[c]           = '0;
          exp_header[c][15 -: AW] = AW'(ant);
          exp_header[c][11:0]     = model_fifo[ant][0];
          for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
            model_fifo[ant][i] = model_fifo[ant][i + 1];
          end
          model_size[ant]--;
          busy[c]     = 1'b1;
          beat_idx[c] = 0;
        end
      end
      // a write into a full FIFO is lost.
      for (int k = 0; k < NA; k++) begin
        if (req_strb_i[k] && !was_full[k]) begin
          model_fifo[k][model_size[k]] = req_word_i[k];
          model_size[k]++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the script did not finish", wd_cycles);
    $display("sim failed");
    $finish;
  end

  // ********************
  // script replay
  // ********************

  initial begin : run_script
    int               fd;
    int               n;
    int               lines;
    int               a;
    int               c;
    int               v;
    logic [31:0]      w;
    logic [63:0]      cmd;
    logic [63:0]      kind;
    logic [8*128-1:0] line;
    rst_n_i            = 1'b0;
    req_strb_i         = '0;
    req_word_i         = '0;
    fft_rd_symbol_i    = '0;
    fft_wr_pointer_x_i = '0;
    resp_ready_i       = '1;
    clear_i            = 1'b0;
    errors             = 0;
    checks             = 0;
    lines              = 0;
    for (int i = 0; i < NC; i++) begin
      fft_rd_antenna_i[i] = AW'(i);
      model_lfsr[i]       = 16'hACE1;
      busy[i]             = 1'b0;
      beat_idx[i]         = 0;
    end
    for (int k = 0; k < NA; k++) begin
      model_size[k] = 0;
    end

    fd = $fopen("verif/ul_oran_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the golden script verif/ul_oran_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          lines++;
        end
      end
      $fclose(fd);
      fd = $fopen("verif/ul_oran_golden.txt", "r");
    end
    wd_cycles = lines * 20 + 2000;

    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        n = $fgets(line, fd);
      end else if (cmd == "REQ") begin
        n = $fscanf(fd, "%d %h", a, w);
        req_strb_i[a] = 1'b1;
        req_word_i[a] = w[11:0];
        advance_cycles(1);
        req_strb_i[a] = 1'b0;
      end else if (cmd == "SYM") begin
        n = $fscanf(fd, "%d %d %d", c, a, v);
        fft_rd_antenna_i[c] = a[AW-1:0];
        fft_rd_symbol_i[c]  = v[3:0];
      end else if (cmd == "XPTR") begin
        n = $fscanf(fd, "%d", c);
        fft_wr_pointer_x_i[c] = 1'b1;
        advance_cycles(1);
        fft_wr_pointer_x_i[c] = 1'b0;
      end else if (cmd == "STALL") begin
        n = $fscanf(fd, "%d %d", c, v);
        resp_ready_i[c] = 1'b0;
        advance_cycles(v);
        resp_ready_i[c] = 1'b1;
      end else if (cmd == "WAIT") begin
        n = $fscanf(fd, "%d", v);
        advance_cycles(v);
      end else if (cmd == "CLEAR") begin
        clear_i = 1'b1;
        advance_cycles(1);
        clear_i = 1'b0;
      end else if (cmd == "EXPECT") begin
        n = $fscanf(fd, "%s %d %h", kind, a, w);
        if (kind == "vld") begin
          compare_value($sformatf("vld_wo_rdy_cnt_o[%0d]", a), 32'(vld_wo_rdy_cnt_o[a]), w);
        end else if (kind == "ovfl") begin
          compare_value($sformatf("fifo_ovfl_cnt_o[%0d]", a), 32'(fifo_ovfl_cnt_o[a]), w);
        end else if (kind == "sreq") begin
          compare_value($sformatf("stale_reqs_cnt_o[%0d]", a), 32'(stale_reqs_cnt_o[a]), w);
        end else if (kind == "sprbs") begin
          compare_value($sformatf("stale_prbs_cnt_o[%0d]", a), 32'(stale_prbs_cnt_o[a]), w);
        end else begin
          errors++;
          $display("unknown counter kind %0s in the golden script", kind);
        end
      end else begin
        errors++;
        $display("unknown command %0s in the golden script", cmd);
        n = $fgets(line, fd);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    for (int i = 0; i < NC; i++) begin
      if (busy[i]) begin
        errors++;
        $display("carrier %0d still had a response in flight when the script ended", i);
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/ul_oran_golden.txt */
# columns: REQ ant word | SYM car ant sym | XPTR car | STALL car cycles | WAIT cycles | CLEAR
# EXPECT kind index value, kind is vld ovfl sreq or sprbs; word and value in hex
SYM 0 0 3
SYM 1 1 5
REQ 0 305
REQ 1 5a1
WAIT 30
REQ 0 30a
REQ 0 311
STALL 0 3
REQ 1 5a2
STALL 1 2
WAIT 40
EXPECT vld 0 0
EXPECT vld 1 0
# antenna 2 is read by no carrier until its FIFO has overflowed twice
REQ 2 700
REQ 2 701
REQ 2 702
REQ 2 703
REQ 2 704
REQ 2 705
WAIT 10
EXPECT ovfl 2 2
SYM 0 2 7
WAIT 60
# long stall counts once, short stall not at all
SYM 0 0 3
REQ 0 3c0
WAIT 3
STALL 0 30
WAIT 20
EXPECT vld 0 1
REQ 0 3c1
WAIT 3
STALL 0 10
WAIT 20
EXPECT vld 0 1
# buffer overwrite while idle and empty, then while busy with a request waiting
XPTR 1
WAIT 10
EXPECT sreq 1 0
EXPECT sprbs 1 0
REQ 0 3d0
REQ 0 3d1
WAIT 2
XPTR 0
WAIT 30
EXPECT sreq 0 1
EXPECT sprbs 0 1
# clear, then saturate the overflow count of antenna 3
CLEAR
WAIT 10
EXPECT vld 0 0
EXPECT ovfl 2 0
EXPECT sreq 0 0
EXPECT sprbs 0 0
REQ 3 900
REQ 3 901
REQ 3 902
REQ 3 903
REQ 3 904
REQ 3 905
REQ 3 906
REQ 3 907
REQ 3 908
REQ 3 909
REQ 3 90a
REQ 3 90b
REQ 3 90c
REQ 3 90d
REQ 3 90e
REQ 3 90f
REQ 3 910
REQ 3 911
REQ 3 912
REQ 3 913
WAIT 10
EXPECT ovfl 3 f
WAIT 10

/* sources.f */
source/ul_oran_pkg.sv
source/request_fifo.sv
source/response_sender.sv
source/alarm_counter.sv
source/alarm_monitor.sv
source/ul_oran_alarm_top.sv
verif/tb_ul_oran_alarm_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ul_oran_alarm_top
FILELIST   := sources.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := sim passed

SIM_BIN    := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
